//--- design/ex_pkg.sv
package ex_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_OR,
    OP_XOR,
    OP_NOR,
    OP_AND,
    OP_PASS_A,
    OP_PASS_B,
    OP_LUI,
    OP_MOVZ,
    OP_MOVN,
    OP_SEB,
    OP_SEH,
    OP_EXT,
    OP_INS
  } alu_op_t;

  typedef enum logic [1:0] {
    RES_ALU,
    RES_SHIFT,
    RES_SET
  } alu_res_t;

  // Major opcodes
  localparam logic [5:0] OPC_SPECIAL  = 6'h00;
  localparam logic [5:0] OPC_ADDIU    = 6'h09;
  localparam logic [5:0] OPC_SLTI     = 6'h0a;
  localparam logic [5:0] OPC_SLTIU    = 6'h0b;
  localparam logic [5:0] OPC_ANDI     = 6'h0c;
  localparam logic [5:0] OPC_ORI      = 6'h0d;
  localparam logic [5:0] OPC_XORI     = 6'h0e;
  localparam logic [5:0] OPC_LUI      = 6'h0f;
  localparam logic [5:0] OPC_SPECIAL3 = 6'h1f;

  // SPECIAL function codes
  localparam logic [5:0] FN_SLL  = 6'h00;
  localparam logic [5:0] FN_SRL  = 6'h02;
  localparam logic [5:0] FN_SRA  = 6'h03;
  localparam logic [5:0] FN_SLLV = 6'h04;
  localparam logic [5:0] FN_SRLV = 6'h06;
  localparam logic [5:0] FN_SRAV = 6'h07;
  localparam logic [5:0] FN_MOVZ = 6'h0a;
  localparam logic [5:0] FN_MOVN = 6'h0b;
  localparam logic [5:0] FN_ADD  = 6'h20;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUB  = 6'h22;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_NOR  = 6'h27;
  localparam logic [5:0] FN_SLT  = 6'h2a;
  localparam logic [5:0] FN_SLTU = 6'h2b;

  // SPECIAL3 function codes, BSHFL picks its operation from the sa field
  localparam logic [5:0] FN_EXT   = 6'h00;
  localparam logic [5:0] FN_INS   = 6'h04;
  localparam logic [5:0] FN_BSHFL = 6'h20;
  localparam logic [4:0] SA_SEB   = 5'h10;
  localparam logic [4:0] SA_SEH   = 5'h18;

  typedef struct packed {
    logic [5:0] opcode;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } instr_r_t;

  typedef struct packed {
    logic [5:0]  opcode;
    reg_idx_t    rs;
    reg_idx_t    rt;
    logic [15:0] imm;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_t;

  typedef struct packed {
    word_t      a;
    word_t      b;
    word_t      c;
    word_t      imm;
    logic       imm_valid;
    logic [4:0] shamt;
    logic       shamt_valid;
    logic       shleft;
    logic       sharith;
    logic       shopsela;
    alu_op_t    alu_op;
    alu_res_t   alu_res_sel;
    logic       alu_set_u;
    reg_idx_t   dest;
    logic       dest_valid;
  } ex_ctrl_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t dest;
    word_t    value;
  } lane_result_t;

endpackage

//--- design/shifter.sv
module shifter #(
  parameter int DATA_WIDTH  = 32,
  parameter int SHAMT_WIDTH = 5
) (
  input  logic [DATA_WIDTH-1:0]  in,
  input  logic [SHAMT_WIDTH-1:0] shamt,
  input  logic                   shleft,
  input  logic                   sharith,
  output logic [DATA_WIDTH-1:0]  out
);

  logic signed [DATA_WIDTH:0] fill;
  logic signed [DATA_WIDTH:0] right;
  logic [DATA_WIDTH-1:0]      left;

  // One extra top bit carries the sign in for arithmetic shifts, zero otherwise
  assign fill  = {sharith & in[DATA_WIDTH-1], in};
  assign right = fill >>> shamt;
  assign left  = in << shamt;

  always_comb begin
    if (shleft) begin
      out = left;
    end else begin
      out = right[DATA_WIDTH-1:0];
    end
  end

endmodule

//--- design/ex_lane.sv
module ex_lane (
  input  logic                 clock,
  input  logic                 rst_n,
  input  ex_pkg::ex_ctrl_t     ctrl,
  input  logic                 ctrl_valid,
  output ex_pkg::lane_result_t res
);

  ex_pkg::word_t    a;
  ex_pkg::word_t    b;
  logic             b_eqz;
  logic [4:0]       shift_val;
  ex_pkg::word_t    shift_operand;
  ex_pkg::word_t    shift_res;
  ex_pkg::word_t    alu_res;
  logic             flag_carry;
  ex_pkg::word_t    set_res;
  logic [4:0]       ext_msbd;
  logic [4:0]       ext_lsb;
  ex_pkg::word_t    ext_mask;
  ex_pkg::word_t    ins_mask;
  ex_pkg::word_t    result;
  logic             valid_q;
  ex_pkg::reg_idx_t dest_q;
  ex_pkg::word_t    value_q;

  assign a = ctrl.a;
  assign b = ctrl.imm_valid ? ctrl.imm : ctrl.b;

  // For INS the msbd field holds the absolute msb of the inserted field
  assign ext_msbd = ctrl.imm[15:11];
  assign ext_lsb  = ctrl.imm[10:6];
  assign ext_mask = 32'hffff_ffff >> (5'd31 - ext_msbd);
  assign ins_mask = ext_mask & (32'hffff_ffff << ext_lsb);

  assign b_eqz = (b == '0);

  assign shift_val     = ctrl.shamt_valid ? ctrl.shamt : a[4:0];
  assign shift_operand = ctrl.shopsela ? a : b;

  shifter #(
    .DATA_WIDTH  (32),
    .SHAMT_WIDTH (5)
  ) u_shifter (
    .in      (shift_operand),
    .shamt   (shift_val),
    .shleft  (ctrl.shleft),
    .sharith (ctrl.sharith),
    .out     (shift_res)
  );

  always_comb begin
    alu_res    = '0;
    flag_carry = 1'b0;
    case (ctrl.alu_op)
      ex_pkg::OP_ADD:    {flag_carry, alu_res} = {1'b0, a} + {1'b0, b};
      ex_pkg::OP_SUB:    {flag_carry, alu_res} = {1'b0, a} - {1'b0, b};
      ex_pkg::OP_OR:     alu_res = a | b;
      ex_pkg::OP_XOR:    alu_res = a ^ b;
      ex_pkg::OP_NOR:    alu_res = ~(a | b);
      ex_pkg::OP_AND:    alu_res = a & b;
      ex_pkg::OP_PASS_A: alu_res = a;
      ex_pkg::OP_PASS_B: alu_res = b;
      ex_pkg::OP_LUI:    alu_res = {b[15:0], 16'h0000};
      ex_pkg::OP_MOVZ:   alu_res = b_eqz ? a : ctrl.c;
      ex_pkg::OP_MOVN:   alu_res = b_eqz ? ctrl.c : a;
      ex_pkg::OP_SEB:    alu_res = {{24{b[7]}}, b[7:0]};
      ex_pkg::OP_SEH:    alu_res = {{16{b[15]}}, b[15:0]};
      ex_pkg::OP_EXT:    alu_res = shift_res & ext_mask;
      // Old rt value comes from the B operand, not the immediate
      ex_pkg::OP_INS:    alu_res = (shift_res & ins_mask) | (ctrl.b & ~ins_mask);
      default:           alu_res = '0;
    endcase
  end

  // Borrow out of the subtract gives the unsigned compare
  always_comb begin
    if (ctrl.alu_set_u) begin
      set_res = {31'b0, flag_carry};
    end else begin
      set_res = {31'b0, (a[31] & ~b[31]) | (alu_res[31] & (~a[31] ^ b[31]))};
    end
  end

  always_comb begin
    case (ctrl.alu_res_sel)
      ex_pkg::RES_SHIFT: result = shift_res;
      ex_pkg::RES_ALU:   result = alu_res;
      default:           result = set_res;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= ctrl_valid && ctrl.dest_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (ctrl_valid) begin
      dest_q  <= ctrl.dest;
      value_q <= result;
    end
  end

  assign res = '{valid: valid_q, dest: dest_q, value: value_q};

endmodule

//--- design/id_decode.sv
module id_decode #(
  parameter int LANES = 4
) (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   issue,
  input  logic [LANES-1:0]       lane_en,
  input  ex_pkg::instr_t         instr [LANES],
  input  ex_pkg::word_t          a_val [LANES],
  input  ex_pkg::word_t          b_val [LANES],
  input  ex_pkg::word_t          c_val [LANES],
  output ex_pkg::ex_ctrl_t       ctrl [LANES],
  output logic [LANES-1:0]       ctrl_valid
);

  function automatic ex_pkg::ex_ctrl_t decode_lane(ex_pkg::instr_t ins, ex_pkg::word_t a_v,
                                                   ex_pkg::word_t b_v, ex_pkg::word_t c_v);
    ex_pkg::ex_ctrl_t d;
    logic             known;
    logic             imm_sext;
    d             = '0;
    d.a           = a_v;
    d.b           = b_v;
    d.c           = c_v;
    d.shamt       = ins.r.shamt;
    d.alu_op      = ex_pkg::OP_ADD;
    d.alu_res_sel = ex_pkg::RES_ALU;
    d.dest        = ins.i.rt;
    known         = 1'b1;
    imm_sext      = 1'b0;

    case (ins.r.opcode)
      ex_pkg::OPC_SPECIAL: begin
        d.dest = ins.r.rd;
        case (ins.r.funct)
          ex_pkg::FN_SLL: begin
            d.shamt_valid = 1'b1;
            d.shleft      = 1'b1;
            d.alu_res_sel = ex_pkg::RES_SHIFT;
          end
          ex_pkg::FN_SRL: begin
            d.shamt_valid = 1'b1;
            d.alu_res_sel = ex_pkg::RES_SHIFT;
          end
          ex_pkg::FN_SRA: begin
            d.shamt_valid = 1'b1;
            d.sharith     = 1'b1;
            d.alu_res_sel = ex_pkg::RES_SHIFT;
          end
          // Variable shifts take the amount from rs, which is A
          ex_pkg::FN_SLLV: begin
            d.shleft      = 1'b1;
            d.alu_res_sel = ex_pkg::RES_SHIFT;
          end
          ex_pkg::FN_SRLV: d.alu_res_sel = ex_pkg::RES_SHIFT;
          ex_pkg::FN_SRAV: begin
            d.sharith     = 1'b1;
            d.alu_res_sel = ex_pkg::RES_SHIFT;
          end
          ex_pkg::FN_MOVZ: d.alu_op = ex_pkg::OP_MOVZ;
          ex_pkg::FN_MOVN: d.alu_op = ex_pkg::OP_MOVN;
          ex_pkg::FN_ADD, ex_pkg::FN_ADDU: d.alu_op = ex_pkg::OP_ADD;
          ex_pkg::FN_SUB, ex_pkg::FN_SUBU: d.alu_op = ex_pkg::OP_SUB;
          ex_pkg::FN_AND: d.alu_op = ex_pkg::OP_AND;
          ex_pkg::FN_OR:  d.alu_op = ex_pkg::OP_OR;
          ex_pkg::FN_XOR: d.alu_op = ex_pkg::OP_XOR;
          ex_pkg::FN_NOR: d.alu_op = ex_pkg::OP_NOR;
          ex_pkg::FN_SLT: begin
            d.alu_op      = ex_pkg::OP_SUB;
            d.alu_res_sel = ex_pkg::RES_SET;
          end
          ex_pkg::FN_SLTU: begin
            d.alu_op      = ex_pkg::OP_SUB;
            d.alu_res_sel = ex_pkg::RES_SET;
            d.alu_set_u   = 1'b1;
          end
          default: known = 1'b0;
        endcase
      end
      ex_pkg::OPC_SPECIAL3: begin
        // The lane reads msbd and lsb out of the immediate, the shift amount is lsb
        d.shamt_valid = 1'b1;
        d.shopsela    = 1'b1;
        case (ins.r.funct)
          ex_pkg::FN_EXT: d.alu_op = ex_pkg::OP_EXT;
          ex_pkg::FN_INS: begin
            d.alu_op = ex_pkg::OP_INS;
            d.shleft = 1'b1;
          end
          ex_pkg::FN_BSHFL: begin
            d.dest = ins.r.rd;
            if (ins.r.shamt == ex_pkg::SA_SEB) begin
              d.alu_op = ex_pkg::OP_SEB;
            end else if (ins.r.shamt == ex_pkg::SA_SEH) begin
              d.alu_op = ex_pkg::OP_SEH;
            end else begin
              known = 1'b0;
            end
          end
          default: known = 1'b0;
        endcase
      end
      ex_pkg::OPC_ADDIU: begin
        d.imm_valid = 1'b1;
        imm_sext    = 1'b1;
      end
      ex_pkg::OPC_SLTI, ex_pkg::OPC_SLTIU: begin
        // SLTIU still sign-extends, only the compare is unsigned
        d.imm_valid   = 1'b1;
        imm_sext      = 1'b1;
        d.alu_op      = ex_pkg::OP_SUB;
        d.alu_res_sel = ex_pkg::RES_SET;
        d.alu_set_u   = (ins.i.opcode == ex_pkg::OPC_SLTIU);
      end
      ex_pkg::OPC_ANDI: begin
        d.imm_valid = 1'b1;
        d.alu_op    = ex_pkg::OP_AND;
      end
      ex_pkg::OPC_ORI: begin
        d.imm_valid = 1'b1;
        d.alu_op    = ex_pkg::OP_OR;
      end
      ex_pkg::OPC_XORI: begin
        d.imm_valid = 1'b1;
        d.alu_op    = ex_pkg::OP_XOR;
      end
      ex_pkg::OPC_LUI: begin
        d.imm_valid = 1'b1;
        d.alu_op    = ex_pkg::OP_LUI;
      end
      default: known = 1'b0;
    endcase

    d.imm        = imm_sext ? {{16{ins.i.imm[15]}}, ins.i.imm} : {16'h0000, ins.i.imm};
    d.dest_valid = known && (d.dest != '0);
    return d;
  endfunction

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      ctrl_valid <= '0;
    end else begin
      ctrl_valid <= issue ? lane_en : '0;
    end
  end

  always_ff @(posedge clock) begin
    for (int l = 0; l < LANES; l++) begin
      if (issue && lane_en[l]) begin
        ctrl[l] <= decode_lane(instr[l], a_val[l], b_val[l], c_val[l]);
      end
    end
  end

endmodule

//--- design/wb_regfile.sv
module wb_regfile #(
  parameter int LANES = 4
) (
  input  logic                 clock,
  input  logic                 rst_n,
  input  ex_pkg::lane_result_t res [LANES],
  input  ex_pkg::reg_idx_t     rd_addr,
  output ex_pkg::word_t        rd_data
);

  ex_pkg::word_t regs [1:31];
  logic [31:1]   wr_en;
  ex_pkg::word_t wr_data [1:31];

  // Lanes are scanned upward so a later lane overrides an earlier one
  // on the same register, as program order within an issue requires
  always_comb begin
    wr_en = '0;
    for (int r = 1; r < 32; r++) begin
      wr_data[r] = '0;
    end
    for (int l = 0; l < LANES; l++) begin
      if (res[l].valid && (res[l].dest != '0)) begin
        wr_en[res[l].dest]   = 1'b1;
        wr_data[res[l].dest] = res[l].value;
      end
    end
  end

  always_ff @(posedge clock) begin
    for (int r = 1; r < 32; r++) begin
      if (!rst_n) begin
        regs[r] <= '0;
      end else if (wr_en[r]) begin
        regs[r] <= wr_data[r];
      end
    end
  end

  // Register 0 is hardwired to zero
  always_comb begin
    if (rd_addr == '0) begin
      rd_data = '0;
    end else begin
      rd_data = regs[rd_addr];
    end
  end

endmodule

//--- design/ex_cluster.sv
module ex_cluster #(
  parameter int LANES = 4
) (
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 issue,
  input  logic [LANES-1:0]     lane_en,
  input  ex_pkg::instr_t       instr [LANES],
  input  ex_pkg::word_t        a_val [LANES],
  input  ex_pkg::word_t        b_val [LANES],
  input  ex_pkg::word_t        c_val [LANES],
  output ex_pkg::lane_result_t res [LANES],
  input  ex_pkg::reg_idx_t     rd_addr,
  output ex_pkg::word_t        rd_data
);

  ex_pkg::ex_ctrl_t ctrl [LANES];
  logic [LANES-1:0] ctrl_valid;

  id_decode #(
    .LANES (LANES)
  ) u_id_decode (
    .clock      (clock),
    .rst_n      (rst_n),
    .issue      (issue),
    .lane_en    (lane_en),
    .instr      (instr),
    .a_val      (a_val),
    .b_val      (b_val),
    .c_val      (c_val),
    .ctrl       (ctrl),
    .ctrl_valid (ctrl_valid)
  );

  for (genvar i = 0; i < LANES; i++) begin : g_lane
    ex_lane u_ex_lane (
      .clock      (clock),
      .rst_n      (rst_n),
      .ctrl       (ctrl[i]),
      .ctrl_valid (ctrl_valid[i]),
      .res        (res[i])
    );
  end

  wb_regfile #(
    .LANES (LANES)
  ) u_wb_regfile (
    .clock   (clock),
    .rst_n   (rst_n),
    .res     (res),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

//--- test/ex_cluster_assertions.sv
module ex_cluster_assertions #(
  parameter int LANES = 4
) (
  input logic                 clock,
  input logic                 rst_n,
  input ex_pkg::lane_result_t res [LANES],
  input ex_pkg::reg_idx_t     rd_addr,
  input ex_pkg::word_t        rd_data
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [LANES-1:0] res_valid;
  int               failures = 0;

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      res_valid[l] = res[l].valid;
    end
  end

  // The synchronous reset clears every lane result by the next cycle
  reset_clears_valid: assert property (@(posedge clock) !rst_n |=> (res_valid == '0))
    else begin
      failures++;
      $error("lane result valid in the cycle after reset");
    end

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    dest_nonzero: assert property (@(posedge clock) disable iff (!rst_n)
                                   res[l].valid |-> (res[l].dest != '0))
      else begin
        failures++;
        $error("lane %0d produced a valid result for register 0", l);
      end
  end

  r0_reads_zero: assert property (@(posedge clock) (rd_addr == '0) |-> (rd_data == '0))
    else begin
      failures++;
      $error("register 0 read back a nonzero value");
    end

endmodule

//--- test/tb_ex_cluster.sv
module tb_ex_cluster;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LANES      = 4;
  localparam int LANE_W     = $clog2(LANES);
  localparam int LATENCY    = 2;
  localparam int WAIT_LIMIT = 20;
  localparam logic [1:0] RND_NONE = 2'd0;
  localparam logic [1:0] RND_ADD  = 2'd1;
  localparam logic [1:0] RND_XOR  = 2'd2;

  typedef struct packed {
    logic [LANE_W-1:0]    lane;
    logic [1:0]           rnd_op;
    ex_pkg::instr_t       instr;
    ex_pkg::word_t        a;
    ex_pkg::word_t        b;
    ex_pkg::word_t        c;
    ex_pkg::lane_result_t expected;
  } case_t;

  logic                 clock;
  logic                 rst_n;
  logic                 issue;
  logic [LANES-1:0]     lane_en;
  ex_pkg::instr_t       instr [LANES];
  ex_pkg::word_t        a_val [LANES];
  ex_pkg::word_t        b_val [LANES];
  ex_pkg::word_t        c_val [LANES];
  ex_pkg::lane_result_t res [LANES];
  ex_pkg::reg_idx_t     rd_addr;
  ex_pkg::word_t        rd_data;

  case_t         cases [$];
  string         case_names [$];
  case_t         burst [$];
  string         burst_names [$];
  ex_pkg::word_t exp_regs [32];
  logic [31:0]   lcg_state;

  ex_cluster #(
    .LANES (LANES)
  ) u_dut (
    .clock   (clock),
    .rst_n   (rst_n),
    .issue   (issue),
    .lane_en (lane_en),
    .instr   (instr),
    .a_val   (a_val),
    .b_val   (b_val),
    .c_val   (c_val),
    .res     (res),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  bind ex_cluster ex_cluster_assertions #(.LANES(LANES)) u_assertions (
    .clock   (clock),
    .rst_n   (rst_n),
    .res     (res),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #2 clock = ~clock;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic ex_pkg::instr_t r_format(logic [5:0] opcode, int rs, int rt, int rd,
                                              int sa, logic [5:0] funct);
    ex_pkg::instr_t w;
    w.r.opcode = opcode;
    w.r.rs     = 5'(rs);
    w.r.rt     = 5'(rt);
    w.r.rd     = 5'(rd);
    w.r.shamt  = 5'(sa);
    w.r.funct  = funct;
    return w;
  endfunction

  function automatic ex_pkg::instr_t i_format(logic [5:0] opcode, int rs, int rt,
                                              logic [15:0] imm);
    ex_pkg::instr_t w;
    w.i.opcode = opcode;
    w.i.rs     = 5'(rs);
    w.i.rt     = 5'(rt);
    w.i.imm    = imm;
    return w;
  endfunction

  function automatic case_t make_case(int lane, ex_pkg::instr_t ins, ex_pkg::word_t a,
                                      ex_pkg::word_t b, ex_pkg::word_t c, logic valid,
                                      int dest, ex_pkg::word_t value);
    case_t t;
    t.lane     = LANE_W'(lane);
    t.rnd_op   = RND_NONE;
    t.instr    = ins;
    t.a        = a;
    t.b        = b;
    t.c        = c;
    t.expected = '{valid: valid, dest: 5'(dest), value: value};
    return t;
  endfunction

  task automatic add_case(input string name, input int lane, input ex_pkg::instr_t ins,
                          input ex_pkg::word_t a, input ex_pkg::word_t b,
                          input ex_pkg::word_t c, input logic valid, input int dest,
                          input ex_pkg::word_t value);
    cases.push_back(make_case(lane, ins, a, b, c, valid, dest, value));
    case_names.push_back(name);
  endtask

  // Operands and expected value are filled in from the LCG when the row runs
  task automatic add_random(input string name, input int lane, input ex_pkg::instr_t ins,
                            input logic [1:0] op, input int dest);
    case_t t;
    t        = make_case(lane, ins, '0, '0, '0, 1'b1, dest, '0);
    t.rnd_op = op;
    cases.push_back(t);
    case_names.push_back(name);
  endtask

  // Burst rows fill the lanes in order with one group of LANES rows per issue
  task automatic add_burst(input string name, input ex_pkg::instr_t ins, input ex_pkg::word_t a,
                           input ex_pkg::word_t b, input int dest, input ex_pkg::word_t value);
    burst.push_back(make_case(burst.size() % LANES, ins, a, b, '0, 1'b1, dest, value));
    burst_names.push_back(name);
  endtask

  task automatic build_table();
    add_random("addu_lcg", 0, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 3, 0, ex_pkg::FN_ADDU),
               RND_ADD, 3);
    add_random("xor_lcg", 1, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 4, 0, ex_pkg::FN_XOR),
               RND_XOR, 4);
    add_case("subu", 2, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 5, 0, ex_pkg::FN_SUBU),
             32'h0000_0005, 32'h0000_0007, 32'h0, 1'b1, 5, 32'hffff_fffe);
    add_case("and", 3, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 6, 0, ex_pkg::FN_AND),
             32'hf0f0_1234, 32'h0ff0_ff00, 32'h0, 1'b1, 6, 32'h00f0_1200);
    add_case("or", 0, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 7, 0, ex_pkg::FN_OR),
             32'h8000_0001, 32'h0000_0f00, 32'h0, 1'b1, 7, 32'h8000_0f01);
    add_case("nor", 1, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 8, 0, ex_pkg::FN_NOR),
             32'h0000_ffff, 32'h00ff_0000, 32'h0, 1'b1, 8, 32'hff00_0000);
    add_case("addiu_neg_imm", 2, i_format(ex_pkg::OPC_ADDIU, 1, 9, 16'hfff0),
             32'h0000_0100, 32'h0, 32'h0, 1'b1, 9, 32'h0000_00f0);
    add_case("ori_zero_ext", 3, i_format(ex_pkg::OPC_ORI, 1, 10, 16'h8001),
             32'h1234_0000, 32'h0, 32'h0, 1'b1, 10, 32'h1234_8001);
    add_case("lui", 0, i_format(ex_pkg::OPC_LUI, 0, 11, 16'hbeef),
             32'h1111_1111, 32'h0, 32'h0, 1'b1, 11, 32'hbeef_0000);
    add_case("slt_neg_pos", 1, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 12, 0, ex_pkg::FN_SLT),
             32'hffff_ffff, 32'h0000_0001, 32'h0, 1'b1, 12, 32'h0000_0001);
    add_case("sltu_neg_pos", 2, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 13, 0, ex_pkg::FN_SLTU),
             32'hffff_ffff, 32'h0000_0001, 32'h0, 1'b1, 13, 32'h0000_0000);
    add_case("slt_pos_neg", 3, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 14, 0, ex_pkg::FN_SLT),
             32'h7fff_ffff, 32'h8000_0000, 32'h0, 1'b1, 14, 32'h0000_0000);
    add_case("sltu_pos_neg", 0, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 15, 0, ex_pkg::FN_SLTU),
             32'h7fff_ffff, 32'h8000_0000, 32'h0, 1'b1, 15, 32'h0000_0001);
    add_case("sll", 1, r_format(ex_pkg::OPC_SPECIAL, 0, 2, 16, 4, ex_pkg::FN_SLL),
             32'h0, 32'h8765_4321, 32'h0, 1'b1, 16, 32'h7654_3210);
    add_case("srl", 2, r_format(ex_pkg::OPC_SPECIAL, 0, 2, 17, 8, ex_pkg::FN_SRL),
             32'h0, 32'h8765_4321, 32'h0, 1'b1, 17, 32'h0087_6543);
    add_case("sra_neg", 3, r_format(ex_pkg::OPC_SPECIAL, 0, 2, 18, 8, ex_pkg::FN_SRA),
             32'h0, 32'h8765_4321, 32'h0, 1'b1, 18, 32'hff87_6543);
    add_case("sllv", 0, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 19, 0, ex_pkg::FN_SLLV),
             32'h0000_0024, 32'h0000_00ff, 32'h0, 1'b1, 19, 32'h0000_0ff0);
    add_case("srlv_neg", 1, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 20, 0, ex_pkg::FN_SRLV),
             32'h0000_0010, 32'hf000_8000, 32'h0, 1'b1, 20, 32'h0000_f000);
    add_case("srav_neg", 2, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 21, 0, ex_pkg::FN_SRAV),
             32'h0000_0004, 32'h8000_0000, 32'h0, 1'b1, 21, 32'hf800_0000);
    add_case("srav_neg_31", 3, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 22, 0, ex_pkg::FN_SRAV),
             32'h0000_001f, 32'h9000_0000, 32'h0, 1'b1, 22, 32'hffff_ffff);
    // For EXT the rd field is size minus one and shamt is lsb
    // For INS the rd field is the msb
    add_case("ext_8_at_4", 0, r_format(ex_pkg::OPC_SPECIAL3, 1, 23, 7, 4, ex_pkg::FN_EXT),
             32'h1234_5678, 32'h0, 32'h0, 1'b1, 23, 32'h0000_0067);
    add_case("ext_16_at_8", 1, r_format(ex_pkg::OPC_SPECIAL3, 1, 24, 15, 8, ex_pkg::FN_EXT),
             32'hdead_beef, 32'h0, 32'h0, 1'b1, 24, 32'h0000_adbe);
    add_case("ext_1_at_31", 2, r_format(ex_pkg::OPC_SPECIAL3, 1, 25, 0, 31, ex_pkg::FN_EXT),
             32'h8000_0000, 32'h0, 32'h0, 1'b1, 25, 32'h0000_0001);
    add_case("ins_8_at_8", 3, r_format(ex_pkg::OPC_SPECIAL3, 1, 26, 15, 8, ex_pkg::FN_INS),
             32'h0000_00ab, 32'h1122_3344, 32'h0, 1'b1, 26, 32'h1122_ab44);
    add_case("ins_4_at_28", 0, r_format(ex_pkg::OPC_SPECIAL3, 1, 27, 31, 28, ex_pkg::FN_INS),
             32'h0000_0005, 32'hffff_ffff, 32'h0, 1'b1, 27, 32'h5fff_ffff);
    add_case("ins_1_at_0", 1, r_format(ex_pkg::OPC_SPECIAL3, 1, 28, 0, 0, ex_pkg::FN_INS),
             32'hffff_fffe, 32'h0000_00ff, 32'h0, 1'b1, 28, 32'h0000_00fe);
    add_case("seb", 2, r_format(ex_pkg::OPC_SPECIAL3, 0, 2, 29, 16, ex_pkg::FN_BSHFL),
             32'h0, 32'h1234_5680, 32'h0, 1'b1, 29, 32'hffff_ff80);
    add_case("seh", 3, r_format(ex_pkg::OPC_SPECIAL3, 0, 2, 30, 24, ex_pkg::FN_BSHFL),
             32'h0, 32'h0000_9abc, 32'h0, 1'b1, 30, 32'hffff_9abc);
    // C carries the old rd value that a move keeps when its condition fails
    add_case("movz_taken", 0, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 31, 0, ex_pkg::FN_MOVZ),
             32'hcafe_f00d, 32'h0, 32'h1111_2222, 1'b1, 31, 32'hcafe_f00d);
    add_case("movz_kept", 1, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 1, 0, ex_pkg::FN_MOVZ),
             32'hcafe_f00d, 32'h1, 32'h1111_2222, 1'b1, 1, 32'h1111_2222);
    add_case("movn_taken", 2, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 2, 0, ex_pkg::FN_MOVN),
             32'h0bad_c0de, 32'h5, 32'h3333_4444, 1'b1, 2, 32'h0bad_c0de);
    add_case("movn_kept", 3, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 3, 0, ex_pkg::FN_MOVN),
             32'h0bad_c0de, 32'h0, 32'h3333_4444, 1'b1, 3, 32'h3333_4444);
    add_case("dest_r0", 0, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 0, 0, ex_pkg::FN_ADDU),
             32'h1, 32'h2, 32'h0, 1'b0, 0, 32'h0);
    add_case("unknown_funct", 1, r_format(ex_pkg::OPC_SPECIAL, 1, 2, 5, 0, 6'h3f),
             32'h1, 32'h2, 32'h0, 1'b0, 5, 32'h0);
    add_case("unknown_opcode", 2, i_format(6'h3e, 1, 6, 16'h1234),
             32'h1, 32'h2, 32'h0, 1'b0, 6, 32'h0);

    add_burst("g0_addu", r_format(ex_pkg::OPC_SPECIAL, 1, 2, 1, 0, ex_pkg::FN_ADDU),
              32'h1, 32'h2, 1, 32'h0000_0003);
    add_burst("g0_subu", r_format(ex_pkg::OPC_SPECIAL, 1, 2, 2, 0, ex_pkg::FN_SUBU),
              32'ha, 32'h3, 2, 32'h0000_0007);
    add_burst("g0_or", r_format(ex_pkg::OPC_SPECIAL, 1, 2, 3, 0, ex_pkg::FN_OR),
              32'hf0, 32'h0f, 3, 32'h0000_00ff);
    add_burst("g0_sll", r_format(ex_pkg::OPC_SPECIAL, 0, 2, 4, 1, ex_pkg::FN_SLL),
              32'h0, 32'h4, 4, 32'h0000_0008);
    add_burst("g1_addiu", i_format(ex_pkg::OPC_ADDIU, 1, 5, 16'h0001),
              32'h9, 32'h0, 5, 32'h0000_000a);
    add_burst("g1_lui", i_format(ex_pkg::OPC_LUI, 0, 6, 16'h1234),
              32'h0, 32'h0, 6, 32'h1234_0000);
    add_burst("g1_xor", r_format(ex_pkg::OPC_SPECIAL, 1, 2, 7, 0, ex_pkg::FN_XOR),
              32'hff, 32'h0f, 7, 32'h0000_00f0);
    add_burst("g1_sra", r_format(ex_pkg::OPC_SPECIAL, 0, 2, 8, 4, ex_pkg::FN_SRA),
              32'h0, 32'h8000_0000, 8, 32'hf800_0000);
    // Lanes 1 and 3 of the last group both write r20 and lane 3 must win
    add_burst("g2_and", r_format(ex_pkg::OPC_SPECIAL, 1, 2, 9, 0, ex_pkg::FN_AND),
              32'hff, 32'h3c, 9, 32'h0000_003c);
    add_burst("g2_addu_r20", r_format(ex_pkg::OPC_SPECIAL, 1, 2, 20, 0, ex_pkg::FN_ADDU),
              32'h100, 32'h1, 20, 32'h0000_0101);
    add_burst("g2_sltu", r_format(ex_pkg::OPC_SPECIAL, 1, 2, 10, 0, ex_pkg::FN_SLTU),
              32'h1, 32'h2, 10, 32'h0000_0001);
    add_burst("g2_or_r20", r_format(ex_pkg::OPC_SPECIAL, 1, 2, 20, 0, ex_pkg::FN_OR),
              32'h0, 32'h0bbb, 20, 32'h0000_0bbb);
  endtask

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_result(input string name, input ex_pkg::lane_result_t expected,
                              input ex_pkg::lane_result_t actual);
    if (actual !== expected) begin
      stop_on_error({$sformatf("FAIL %s: expected valid=%0b dest=%0d value=%h", name,
                               expected.valid, expected.dest, expected.value),
                     $sformatf(", actual valid=%0b dest=%0d value=%h", actual.valid,
                               actual.dest, actual.value)});
    end
  endtask

  task automatic check_reg(input string name, input ex_pkg::word_t expected,
                           input ex_pkg::word_t actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic clear_inputs();
    issue   = 1'b0;
    lane_en = '0;
    for (int l = 0; l < LANES; l++) begin
      instr[l] = '0;
      a_val[l] = '0;
      b_val[l] = '0;
      c_val[l] = '0;
    end
  endtask

  task automatic read_reg(input int r, output ex_pkg::word_t data);
    rd_addr = 5'(r);
    #1;
    data = rd_data;
  endtask

  task automatic run_case(input int idx);
    case_t         t;
    ex_pkg::word_t got;
    int            waited;
    t = cases[idx];
    if (t.rnd_op != RND_NONE) begin
      t.a = lcg_next();
      t.b = lcg_next();
      t.expected.value = (t.rnd_op == RND_ADD) ? t.a + t.b : t.a ^ t.b;
    end
    @(negedge clock);
    issue            = 1'b1;
    lane_en          = '0;
    lane_en[t.lane]  = 1'b1;
    instr[t.lane]    = t.instr;
    a_val[t.lane]    = t.a;
    b_val[t.lane]    = t.b;
    c_val[t.lane]    = t.c;
    @(negedge clock);
    clear_inputs();
    waited = 1;
    if (t.expected.valid) begin
      while (!res[t.lane].valid) begin
        if (waited >= WAIT_LIMIT) begin
          stop_on_error($sformatf("timeout waiting for a result of %s on lane %0d",
                                  case_names[idx], t.lane));
        end
        @(negedge clock);
        waited++;
      end
      if (waited != LATENCY) begin
        stop_on_error($sformatf("result of %s arrived after %0d cycles instead of %0d",
                                case_names[idx], waited, LATENCY));
      end
      check_result(case_names[idx], t.expected, res[t.lane]);
      exp_regs[t.expected.dest] = t.expected.value;
      @(negedge clock);
    end else begin
      repeat (LATENCY) begin
        @(negedge clock);
        if (res[t.lane].valid) begin
          stop_on_error($sformatf("%s produced a valid result that should be suppressed",
                                  case_names[idx]));
        end
      end
    end
    read_reg(t.expected.dest, got);
    check_reg({case_names[idx], "_readback"}, exp_regs[t.expected.dest], got);
  endtask

  task automatic run_burst();
    ex_pkg::word_t got;
    int            groups;
    int            idx;
    groups = burst.size() / LANES;
    @(negedge clock);
    // Each group retires LATENCY cycles after its issue while later groups go in
    for (int n = 0; n < groups + LATENCY; n++) begin
      if (n < groups) begin
        issue   = 1'b1;
        lane_en = '1;
        for (int l = 0; l < LANES; l++) begin
          instr[l] = burst[n * LANES + l].instr;
          a_val[l] = burst[n * LANES + l].a;
          b_val[l] = burst[n * LANES + l].b;
          c_val[l] = burst[n * LANES + l].c;
        end
      end else begin
        clear_inputs();
      end
      if (n >= LATENCY) begin
        for (int l = 0; l < LANES; l++) begin
          idx = (n - LATENCY) * LANES + l;
          check_result(burst_names[idx], burst[idx].expected, res[l]);
          exp_regs[burst[idx].expected.dest] = burst[idx].expected.value;
        end
      end
      @(negedge clock);
    end
    for (int r = 0; r < 32; r++) begin
      read_reg(r, got);
      check_reg($sformatf("burst_r%0d", r), exp_regs[r], got);
    end
  endtask

  initial begin
    ex_pkg::word_t got;
    lcg_state   = 32'h1f00_6bad;
    rst_n       = 1'b0;
    rd_addr     = '0;
    clear_inputs();
    for (int r = 0; r < 32; r++) begin
      exp_regs[r] = '0;
    end
    build_table();
    repeat (16) @(negedge clock);
    rst_n = 1'b1;
    for (int r = 0; r < 32; r++) begin
      read_reg(r, got);
      check_reg($sformatf("reset_r%0d", r), 32'h0, got);
    end
    for (int i = 0; i < cases.size(); i++) begin
      run_case(i);
    end
    run_burst();
    if (u_dut.u_assertions.failures == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- ex_cluster.f
design/ex_pkg.sv
design/shifter.sv
design/ex_lane.sv
design/id_decode.sv
design/wb_regfile.sv
design/ex_cluster.sv
test/ex_cluster_assertions.sv
test/tb_ex_cluster.sv

//--- Makefile
TOP := tb_ex_cluster

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) \
		-f ex_cluster.f --Mdir obj_dir -o $(TOP)

run: build
	-./obj_dir/$(TOP) > sim.log 2>&1
	cat sim.log
	! grep -q "Test FAILED" sim.log
	grep -q "Test OK" sim.log

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps --top-module $(TOP) \
		-f ex_cluster.f

clean:
	rm -rf obj_dir sim.log
